/* hw/mem_pkg.sv */
package mem_pkg;

    parameter int XLEN      = 64;
    parameter int ADDR_W    = 32;
    parameter int REG_IDX_W = 5;

    // Low two bits give the access size, bit 2 marks zero extension.
    typedef enum logic [2:0] {
        LD_B  = 3'd0,
        LD_H  = 3'd1,
        LD_W  = 3'd2,
        LD_D  = 3'd3,
        LD_BU = 3'd4,
        LD_HU = 3'd5,
        LD_WU = 3'd6
    } ld_op_e;

    typedef enum logic [1:0] {
        ST_B = 2'd0,
        ST_H = 2'd1,
        ST_W = 2'd2,
        ST_D = 2'd3
    } st_op_e;

    typedef enum logic [2:0] {
        CSR_NONE = 3'd0,
        CSR_RW   = 3'd1,
        CSR_RS   = 3'd2,
        CSR_RC   = 3'd3,
        CSR_RWI  = 3'd4,
        CSR_RSI  = 3'd5,
        CSR_RCI  = 3'd6
    } csr_op_e;

    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MIP      = 12'h344
    } csr_addr_e;

    typedef struct packed {
        logic      inst_valid;
        logic      mem_read;
        logic      mem_write;
        ld_op_e    ld_op;
        st_op_e    st_op;
        logic      inst_csr;
        csr_op_e   csr_op;
        csr_addr_e csr_addr;
        logic      ecall;
        logic      ebreak;
        logic      mret;
    } mem_ctrl_t;

    typedef struct packed {
        logic                 rs_en;
        logic [REG_IDX_W-1:0] rs_idx;
        logic [XLEN-1:0]      rs_data;
    } fwd_src_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [7:0]        sel;
        logic [XLEN-1:0]   dat;
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] dat;
    } wb_rsp_t;

    parameter logic [XLEN-1:0] CAUSE_ECALL = 64'd11;
    parameter logic [XLEN-1:0] CAUSE_BREAK = 64'd3;
    parameter logic [XLEN-1:0] CAUSE_MTI   = {1'b1, 63'd7};  // Interrupt bit set.

endpackage

/* hw/mem_forward.sv */
`timescale 1ns/10ps
module mem_forward (
    input  mem_pkg::fwd_src_t              rs1_i,
    input  mem_pkg::fwd_src_t              rs2_i,
    input  logic                           wb_rd_en_i,
    input  logic [mem_pkg::REG_IDX_W-1:0]  wb_rd_idx_i,
    input  logic [mem_pkg::XLEN-1:0]       wb_rd_data_i,
    output logic [mem_pkg::XLEN-1:0]       op1_o,
    output logic [mem_pkg::XLEN-1:0]       op2_o
);
    import mem_pkg::*;

    function automatic logic [XLEN-1:0] fwd_pick(
        input fwd_src_t             rs,
        input logic                 rd_en,
        input logic [REG_IDX_W-1:0] rd_idx,
        input logic [XLEN-1:0]      rd_data
    );
        // x0 is hardwired, so a match on it is ignored.
        if (rs.rs_en && (rs.rs_idx != '0) && rd_en && (rd_idx == rs.rs_idx)) begin
            return rd_data;
        end
        return rs.rs_data;
    endfunction

    assign op1_o = fwd_pick(rs1_i, wb_rd_en_i, wb_rd_idx_i, wb_rd_data_i);
    assign op2_o = fwd_pick(rs2_i, wb_rd_en_i, wb_rd_idx_i, wb_rd_data_i);

endmodule

/* hw/mem_lsu.sv */
`timescale 1ns/10ps
module mem_lsu (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  mem_pkg::mem_ctrl_t          ctrl_i,
    input  logic                        irq_take_i,
    input  logic [mem_pkg::ADDR_W-1:0]  addr_i,
    input  logic [mem_pkg::XLEN-1:0]    wdata_i,
    output mem_pkg::wb_req_t            wb_o,
    input  mem_pkg::wb_rsp_t            wb_i,
    output logic [mem_pkg::XLEN-1:0]    rdata_o,
    output logic                        access_ok_o
);
    import mem_pkg::*;

    typedef enum logic {
        IDLE,
        BUSY
    } state_e;

    state_e          state_q;
    state_e          state_d;
    logic            is_mem;
    logic            busy;
    logic [1:0]      size;
    logic [7:0]      sel_base;
    logic [5:0]      shamt;
    logic [XLEN-1:0] rshift;

    assign is_mem = ctrl_i.mem_read | ctrl_i.mem_write;
    assign busy   = (state_q == BUSY);
    assign shamt  = {addr_i[2:0], 3'b000};
    assign size   = ctrl_i.mem_write ? ctrl_i.st_op : ctrl_i.ld_op[1:0];

    always_comb begin
        case (size)
            2'd0:    sel_base = 8'h01;
            2'd1:    sel_base = 8'h03;
            2'd2:    sel_base = 8'h0f;
            default: sel_base = 8'hff;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (ctrl_i.inst_valid && is_mem && !irq_take_i) begin
                    state_d = BUSY;
                end
            end
            BUSY: begin
                if (wb_i.ack) begin
                    state_d = IDLE;  // Drop cyc/stb the cycle after ack.
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Address and data come straight from the held pipeline inputs.
    always_comb begin
        wb_o.cyc = busy;
        wb_o.stb = busy;
        wb_o.we  = ctrl_i.mem_write;
        wb_o.adr = {addr_i[ADDR_W-1:3], 3'b000};
        wb_o.sel = sel_base << addr_i[2:0];
        wb_o.dat = wdata_i << shamt;
    end

    assign rshift = wb_i.dat >> shamt;

    always_comb begin
        case (ctrl_i.ld_op)
            LD_B:    rdata_o = {{56{rshift[7]}}, rshift[7:0]};
            LD_H:    rdata_o = {{48{rshift[15]}}, rshift[15:0]};
            LD_W:    rdata_o = {{32{rshift[31]}}, rshift[31:0]};
            LD_BU:   rdata_o = {56'b0, rshift[7:0]};
            LD_HU:   rdata_o = {48'b0, rshift[15:0]};
            LD_WU:   rdata_o = {32'b0, rshift[31:0]};
            default: rdata_o = rshift;
        endcase
    end

    // A pending interrupt skips the access; the trap is taken instead.
    assign access_ok_o = ctrl_i.inst_valid &
                         (busy ? wb_i.ack : (~is_mem | irq_take_i));

endmodule

/* hw/mem_addr_decode.sv */
`timescale 1ns/10ps
module mem_addr_decode #(
    parameter logic [mem_pkg::ADDR_W-1:0] CLINT_BASE = 32'h0200_0000
) (
    input  mem_pkg::wb_req_t  wb_i,
    output mem_pkg::wb_rsp_t  wb_o,
    output mem_pkg::wb_req_t  clint_req_o,
    input  mem_pkg::wb_rsp_t  clint_rsp_i,
    output mem_pkg::wb_req_t  ext_req_o,
    input  mem_pkg::wb_rsp_t  ext_rsp_i
);
    import mem_pkg::*;

    localparam logic [ADDR_W-1:0] CLINT_SPAN = 'h1_0000;  // 64 KiB window.

    logic [ADDR_W-1:0] offset;
    logic              hit;

    assign offset = wb_i.adr - CLINT_BASE;
    assign hit    = (offset < CLINT_SPAN);

    always_comb begin
        clint_req_o     = wb_i;
        clint_req_o.cyc = wb_i.cyc & hit;
        clint_req_o.stb = wb_i.stb & hit;

        ext_req_o       = wb_i;
        ext_req_o.cyc   = wb_i.cyc & ~hit;
        ext_req_o.stb   = wb_i.stb & ~hit;

        // Only the strobed slave can ack.
        wb_o = hit ? clint_rsp_i : ext_rsp_i;
    end

endmodule

/* hw/mem_clint.sv */
`timescale 1ns/10ps
module mem_clint (
    input  logic              clk,
    input  logic              rst_n_i,
    input  mem_pkg::wb_req_t  wb_i,
    output mem_pkg::wb_rsp_t  wb_o,
    output logic              timer_pending_o
);
    import mem_pkg::*;

    localparam logic [15:0] MTIMECMP_OFF = 16'h4000;
    localparam logic [15:0] MTIME_OFF    = 16'hbff8;

    logic [XLEN-1:0] mtime_q;
    logic [XLEN-1:0] mtimecmp_q;
    logic [XLEN-1:0] rdata_q;
    logic            ack_q;
    logic            pending_q;
    logic            req;
    logic            wr_mtime;
    logic            wr_cmp;

    function automatic logic [XLEN-1:0] lane_merge(
        input logic [XLEN-1:0] old,
        input logic [XLEN-1:0] dat,
        input logic [7:0]      sel
    );
        logic [XLEN-1:0] res;
        res = old;
        for (int i = 0; i < 8; i++) begin
            if (sel[i]) begin
                res[i*8 +: 8] = dat[i*8 +: 8];
            end
        end
        return res;
    endfunction

    assign req      = wb_i.cyc & wb_i.stb & ~ack_q;  // One ack per strobe.
    assign wr_mtime = req & wb_i.we & (wb_i.adr[15:0] == MTIME_OFF);
    assign wr_cmp   = req & wb_i.we & (wb_i.adr[15:0] == MTIMECMP_OFF);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q      <= 1'b0;
            pending_q  <= 1'b0;
            mtime_q    <= '0;
            mtimecmp_q <= '1;
        end else begin
            ack_q     <= req;
            pending_q <= (mtime_q >= mtimecmp_q);
            if (wr_mtime) begin
                mtime_q <= lane_merge(mtime_q, wb_i.dat, wb_i.sel);
            end else begin
                mtime_q <= mtime_q + 1'b1;
            end
            if (wr_cmp) begin
                mtimecmp_q <= lane_merge(mtimecmp_q, wb_i.dat, wb_i.sel);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            case (wb_i.adr[15:0])
                MTIME_OFF:    rdata_q <= mtime_q;
                MTIMECMP_OFF: rdata_q <= mtimecmp_q;
                default:      rdata_q <= '0;
            endcase
        end
    end

    assign wb_o            = '{ack: ack_q, dat: rdata_q};
    assign timer_pending_o = pending_q;

endmodule

/* hw/mem_csr.sv */
`timescale 1ns/10ps
module mem_csr (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  mem_pkg::mem_ctrl_t          ctrl_i,
    input  logic                        access_ok_i,
    input  logic [mem_pkg::XLEN-1:0]    rs1_data_i,
    input  logic [mem_pkg::XLEN-1:0]    imm_i,
    input  logic [mem_pkg::ADDR_W-1:0]  pc_i,
    input  logic                        intp_en_i,
    input  logic                        timer_pending_i,
    output logic                        irq_take_o,
    output logic [mem_pkg::XLEN-1:0]    csr_rdata_o,
    output logic                        trap_o,
    output logic [mem_pkg::ADDR_W-1:0]  nxt_pc_o
);
    import mem_pkg::*;

    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam int MTI_BIT  = 7;  // MTIE in mie, MTIP in mip.

    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mip;
    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] new_val;
    logic [XLEN-1:0] src;
    logic            is_imm;
    logic            commit;
    logic            take_trap;
    logic            do_mret;
    logic            csr_we;

    assign irq_take_o = timer_pending_i & mie_q[MTI_BIT] & mstatus_q[MIE_BIT] & intp_en_i;

    assign commit    = ctrl_i.inst_valid & access_ok_i;
    assign take_trap = irq_take_o | ctrl_i.ecall | ctrl_i.ebreak;
    assign do_mret   = ctrl_i.mret & ~take_trap;
    assign csr_we    = commit & ctrl_i.inst_csr & (ctrl_i.csr_op != CSR_NONE) & ~take_trap;

    assign trap_o   = commit & (take_trap | ctrl_i.mret);
    assign nxt_pc_o = do_mret ? mepc_q[ADDR_W-1:0] : {mtvec_q[ADDR_W-1:2], 2'b00};

    assign mip = {{(XLEN-MTI_BIT-1){1'b0}}, timer_pending_i, {MTI_BIT{1'b0}}};

    always_comb begin
        case (ctrl_i.csr_addr)
            CSR_MSTATUS:  old_val = mstatus_q;
            CSR_MIE:      old_val = mie_q;
            CSR_MTVEC:    old_val = mtvec_q;
            CSR_MSCRATCH: old_val = mscratch_q;
            CSR_MEPC:     old_val = mepc_q;
            CSR_MCAUSE:   old_val = mcause_q;
            CSR_MIP:      old_val = mip;
            default:      old_val = '0;
        endcase
    end

    assign is_imm = ctrl_i.csr_op inside {CSR_RWI, CSR_RSI, CSR_RCI};
    assign src    = is_imm ? {{(XLEN-5){1'b0}}, imm_i[4:0]} : rs1_data_i;

    always_comb begin
        case (ctrl_i.csr_op)
            CSR_RW, CSR_RWI: new_val = src;
            CSR_RS, CSR_RSI: new_val = old_val | src;
            CSR_RC, CSR_RCI: new_val = old_val & ~src;
            default:         new_val = old_val;
        endcase
    end

    assign csr_rdata_o = old_val;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mstatus_q  <= '0;
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mie_q      <= '0;
            mscratch_q <= '0;
        end else if (commit && take_trap) begin
            // Interrupt wins over ecall and ebreak.
            mepc_q              <= {{(XLEN-ADDR_W){1'b0}}, pc_i};
            mcause_q            <= irq_take_o ? CAUSE_MTI :
                                   (ctrl_i.ecall ? CAUSE_ECALL : CAUSE_BREAK);
            mstatus_q[MPIE_BIT] <= mstatus_q[MIE_BIT];
            mstatus_q[MIE_BIT]  <= 1'b0;
        end else if (commit && do_mret) begin
            mstatus_q[MIE_BIT]  <= mstatus_q[MPIE_BIT];
            mstatus_q[MPIE_BIT] <= 1'b1;
        end else if (csr_we) begin
            case (ctrl_i.csr_addr)
                CSR_MSTATUS:  mstatus_q  <= new_val;
                CSR_MIE:      mie_q      <= new_val;
                CSR_MTVEC:    mtvec_q    <= new_val;
                CSR_MSCRATCH: mscratch_q <= new_val;
                CSR_MEPC:     mepc_q     <= new_val;
                CSR_MCAUSE:   mcause_q   <= new_val;
                default: ;  // mip is read only.
            endcase
        end
    end

endmodule

/* hw/mem_top.sv */
`timescale 1ns/10ps
module mem_top #(
    parameter logic [mem_pkg::ADDR_W-1:0] CLINT_BASE = 32'h0200_0000
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  mem_pkg::mem_ctrl_t             ctrl_i,
    input  mem_pkg::fwd_src_t              rs1_i,
    input  mem_pkg::fwd_src_t              rs2_i,
    input  logic                           wb_rd_en_i,
    input  logic [mem_pkg::REG_IDX_W-1:0]  wb_rd_idx_i,
    input  logic [mem_pkg::XLEN-1:0]       wb_rd_data_i,
    input  logic [mem_pkg::XLEN-1:0]       alu_data_i,
    input  logic [mem_pkg::XLEN-1:0]       imm_i,
    input  logic [mem_pkg::ADDR_W-1:0]     pc_i,
    input  logic                           intp_en_i,
    output logic                           access_ok_o,
    output logic [mem_pkg::XLEN-1:0]       rd_data_o,
    output logic                           trap_o,
    output logic [mem_pkg::ADDR_W-1:0]     nxt_pc_o,
    output mem_pkg::wb_req_t               wb_o,
    input  mem_pkg::wb_rsp_t               wb_i
);
    import mem_pkg::*;

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] lsu_rdata;
    logic [XLEN-1:0] csr_rdata;
    logic            irq_take;
    logic            timer_pending;
    wb_req_t         lsu_req;
    wb_rsp_t         lsu_rsp;
    wb_req_t         clint_req;
    wb_rsp_t         clint_rsp;

    mem_forward u_forward (
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .wb_rd_en_i   (wb_rd_en_i),
        .wb_rd_idx_i  (wb_rd_idx_i),
        .wb_rd_data_i (wb_rd_data_i),
        .op1_o        (op1),
        .op2_o        (op2)
    );

    mem_lsu u_lsu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ctrl_i      (ctrl_i),
        .irq_take_i  (irq_take),
        .addr_i      (alu_data_i[ADDR_W-1:0]),
        .wdata_i     (op2),
        .wb_o        (lsu_req),
        .wb_i        (lsu_rsp),
        .rdata_o     (lsu_rdata),
        .access_ok_o (access_ok_o)
    );

    mem_addr_decode #(
        .CLINT_BASE (CLINT_BASE)
    ) u_decode (
        .wb_i        (lsu_req),
        .wb_o        (lsu_rsp),
        .clint_req_o (clint_req),
        .clint_rsp_i (clint_rsp),
        .ext_req_o   (wb_o),
        .ext_rsp_i   (wb_i)
    );

    mem_clint u_clint (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .wb_i            (clint_req),
        .wb_o            (clint_rsp),
        .timer_pending_o (timer_pending)
    );

    mem_csr u_csr (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .ctrl_i          (ctrl_i),
        .access_ok_i     (access_ok_o),
        .rs1_data_i      (op1),
        .imm_i           (imm_i),
        .pc_i            (pc_i),
        .intp_en_i       (intp_en_i),
        .timer_pending_i (timer_pending),
        .irq_take_o      (irq_take),
        .csr_rdata_o     (csr_rdata),
        .trap_o          (trap_o),
        .nxt_pc_o        (nxt_pc_o)
    );

    // Loads return bus data, CSR ops the old CSR value.
    always_comb begin
        if (ctrl_i.mem_read) begin
            rd_data_o = lsu_rdata;
        end else if (ctrl_i.inst_csr) begin
            rd_data_o = csr_rdata;
        end else begin
            rd_data_o = alu_data_i;
        end
    end

endmodule

/* tests/mem_top_properties.sv */
`timescale 1ns/10ps
module mem_top_properties (
    input logic               clk,
    input logic               rst_n_i,
    input mem_pkg::mem_ctrl_t ctrl_i,
    input mem_pkg::wb_req_t   req_i,
    input mem_pkg::wb_rsp_t   rsp_i,
    input logic               access_ok_i,
    input logic               irq_take_i
);

    stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_i.stb |-> req_i.cyc)
        else $error("stb asserted outside a bus cycle");

    // Request fields hold until the slave acks.
    req_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        (req_i.stb && !rsp_i.ack) |=> (req_i.stb && $stable(req_i.adr) && $stable(req_i.we)
                                       && $stable(req_i.sel) && $stable(req_i.dat)))
        else $error("bus request changed before ack");

    ok_needs_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        access_ok_i |-> ctrl_i.inst_valid)
        else $error("access_ok high without a valid instruction");

    no_start_on_irq: assert property (@(posedge clk) disable iff (!rst_n_i)
        (irq_take_i && !req_i.cyc) |=> !req_i.cyc)
        else $error("bus cycle started while an interrupt was taken");

endmodule

bind mem_lsu mem_top_properties u_props (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .ctrl_i      (ctrl_i),
    .req_i       (wb_o),
    .rsp_i       (wb_i),
    .access_ok_i (access_ok_o),
    .irq_take_i  (irq_take_i)
);

/* tests/mem_top_tb.sv */
`timescale 1ns/10ps
module mem_top_tb;
    import mem_pkg::*;

    localparam int CLK_HALF   = 4;
    localparam int RST_CYCLES = 4;
    localparam int MEM_OPS    = 96;  // Upper bound on loads and stores over all tests.
    localparam int MEM_OP_CYC = 6;   // Launch, ack after up to 3 wait states, retire.
    localparam int SHORT_OPS  = 48;  // ALU, CSR and trap instructions.
    localparam int POLL_MAX   = 100;
    localparam int MAX_CYCLES = RST_CYCLES + MEM_OPS * MEM_OP_CYC + SHORT_OPS * 2
                                + POLL_MAX + 50;
    localparam logic [31:0] MTIMECMP_ADR = 32'h0200_4000;
    localparam logic [31:0] MTIME_ADR    = 32'h0200_bff8;

    logic        clk;
    logic        rst_n;
    mem_ctrl_t   ctrl;
    fwd_src_t    rs1;
    fwd_src_t    rs2;
    logic        wb_rd_en;
    logic [4:0]  wb_rd_idx;
    logic [63:0] wb_rd_data;
    logic [63:0] alu_data;
    logic [63:0] imm;
    logic [31:0] pc;
    logic        intp_en;
    logic        access_ok;
    logic [63:0] rd_data;
    logic        trap;
    logic [31:0] nxt_pc;
    wb_req_t     ext_req;
    wb_rsp_t     ext_rsp = '0;

    logic [63:0] mem [0:511];
    logic [7:0]  ref_mem [0:4095];  // Byte image of the external memory.
    logic [1:0]  wait_cnt = 2'd0;
    int          seed = 53896;
    int          ext_cycles = 0;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    logic [63:0] res;
    logic        res_trap;
    logic [31:0] res_pc;
    int          res_wait;

    mem_top uut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .ctrl_i       (ctrl),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .wb_rd_en_i   (wb_rd_en),
        .wb_rd_idx_i  (wb_rd_idx),
        .wb_rd_data_i (wb_rd_data),
        .alu_data_i   (alu_data),
        .imm_i        (imm),
        .pc_i         (pc),
        .intp_en_i    (intp_en),
        .access_ok_o  (access_ok),
        .rd_data_o    (rd_data),
        .trap_o       (trap),
        .nxt_pc_o     (nxt_pc),
        .wb_o         (ext_req),
        .wb_i         (ext_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // External Wishbone slave with 0 to 3 random wait states.
    always @(posedge clk) begin
        if (!rst_n) begin
            ext_rsp.ack <= 1'b0;
            wait_cnt    <= 2'd0;
        end else begin
            ext_rsp.ack <= 1'b0;
            if (ext_req.cyc && ext_req.stb) begin
                ext_cycles <= ext_cycles + 1;
            end
            if (ext_req.cyc && ext_req.stb && !ext_rsp.ack) begin
                if (wait_cnt != 2'd0) begin
                    wait_cnt <= wait_cnt - 2'd1;
                end else begin
                    ext_rsp.ack <= 1'b1;
                    ext_rsp.dat <= mem[ext_req.adr[11:3]];
                    wait_cnt    <= 2'($random(seed));
                    for (int b = 0; b < 8; b++) begin
                        if (ext_req.we && ext_req.sel[b]) begin
                            mem[ext_req.adr[11:3]][b*8 +: 8] <= ext_req.dat[b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [63:0] fill_word(input int idx);
        logic [15:0] a;
        a = idx[15:0];
        return {a ^ 16'hc3a5, ~a, a, a ^ 16'h0ff0};
    endfunction

    function automatic logic [63:0] rnd64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic int load_size(input ld_op_e op);
        case (op)
            LD_B, LD_BU: return 1;
            LD_H, LD_HU: return 2;
            LD_W, LD_WU: return 4;
            default:     return 8;
        endcase
    endfunction

    // Little-endian gather from the byte image followed by extension.
    function automatic logic [63:0] exp_load(input ld_op_e op, input logic [31:0] adr);
        logic [63:0] v;
        int          n;
        n = load_size(op);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i*8 +: 8] = ref_mem[adr[11:0] + i];
        end
        if ((op inside {LD_B, LD_H, LD_W}) && v[n*8-1]) begin
            for (int i = n * 8; i < 64; i++) begin
                v[i] = 1'b1;
            end
        end
        return v;
    endfunction

    task automatic init_all();
        logic [63:0] w;
        ctrl       = '0;
        rs1        = '0;
        rs2        = '0;
        wb_rd_en   = 1'b0;
        wb_rd_idx  = 5'd0;
        wb_rd_data = '0;
        alu_data   = '0;
        imm        = '0;
        pc         = '0;
        intp_en    = 1'b0;
        rst_n      = 1'b0;
        for (int i = 0; i < 512; i++) begin
            w      = fill_word(i);
            mem[i] = w;
            for (int b = 0; b < 8; b++) begin
                ref_mem[i*8 + b] = w[b*8 +: 8];
            end
        end
    endtask

    task automatic compare_value(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic confirm(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    // Holds the instruction until access_ok and samples at the falling edge.
    task automatic issue();
        res_wait = 0;
        @(negedge clk);
        while (!access_ok) begin
            res_wait++;
            @(negedge clk);
        end
        res      = rd_data;
        res_trap = trap;
        res_pc   = nxt_pc;
        @(posedge clk);
        #1;
        ctrl = '0;
    endtask

    task automatic write_mem(input st_op_e op, input logic [31:0] adr, input fwd_src_t src);
        ctrl            = '0;
        ctrl.inst_valid = 1'b1;
        ctrl.mem_write  = 1'b1;
        ctrl.st_op      = op;
        alu_data        = {32'd0, adr};
        rs2             = src;
        issue();
    endtask

    task automatic read_mem(input ld_op_e op, input logic [31:0] adr);
        ctrl            = '0;
        ctrl.inst_valid = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.ld_op      = op;
        alu_data        = {32'd0, adr};
        issue();
    endtask

    task automatic run_csr(input csr_op_e op, input csr_addr_e adr, input logic [63:0] src,
                           input logic [63:0] imm_v);
        ctrl            = '0;
        ctrl.inst_valid = 1'b1;
        ctrl.inst_csr   = 1'b1;
        ctrl.csr_op     = op;
        ctrl.csr_addr   = adr;
        rs1             = '{rs_en: 1'b1, rs_idx: 5'd3, rs_data: src};
        imm             = imm_v;
        issue();
    endtask

    task automatic system_inst(input logic ec, input logic eb, input logic mr);
        ctrl            = '0;
        ctrl.inst_valid = 1'b1;
        ctrl.ecall      = ec;
        ctrl.ebreak     = eb;
        ctrl.mret       = mr;
        issue();
    endtask

    task automatic alu_inst(input logic [63:0] v);
        ctrl            = '0;
        ctrl.inst_valid = 1'b1;
        alu_data        = v;
        issue();
    endtask

    task automatic store_ref(input st_op_e op, input logic [31:0] adr, input logic [63:0] data);
        int n;
        n = 1 << op;
        for (int i = 0; i < n; i++) begin
            ref_mem[adr[11:0] + i] = data[i*8 +: 8];
        end
        write_mem(op, adr, '{rs_en: 1'b1, rs_idx: 5'd7, rs_data: data});
    endtask

    task automatic access_widths();
        logic [31:0] base;
        ld_op_e      op;
        base = 32'h0000_0100;
        store_ref(ST_D, base, rnd64());
        store_ref(ST_D, base + 8, rnd64());
        for (int o = 0; o < 8; o++) begin
            store_ref(ST_B, base + o, rnd64());
        end
        for (int o = 0; o < 8; o += 2) begin
            store_ref(ST_H, base + o, rnd64());
        end
        for (int o = 0; o < 8; o += 4) begin
            store_ref(ST_W, base + o, rnd64());
        end
        for (int k = 0; k < 7; k++) begin
            op = ld_op_e'(k);
            for (int o = 0; o < 16; o += load_size(op)) begin
                read_mem(op, base + o);
                compare_value($sformatf("widths %s +%0d", op.name(), o),
                              exp_load(op, base + o), res);
            end
        end
    endtask

    task automatic fwd_case(input string name, input logic en, input logic [4:0] idx,
                            input logic wen, input logic [4:0] widx, input logic take_wb);
        logic [63:0] own;
        logic [63:0] fwd;
        own        = rnd64();
        fwd        = rnd64();
        wb_rd_en   = wen;
        wb_rd_idx  = widx;
        wb_rd_data = fwd;
        write_mem(ST_D, 32'h0000_0200, '{rs_en: en, rs_idx: idx, rs_data: own});
        wb_rd_en   = 1'b0;
        read_mem(LD_D, 32'h0000_0200);
        compare_value(name, take_wb ? fwd : own, res);
    endtask

    task automatic forwarding_and_alu();
        logic [63:0] v;
        fwd_case("forward match", 1'b1, 5'd9, 1'b1, 5'd9, 1'b1);
        fwd_case("forward other rd", 1'b1, 5'd9, 1'b1, 5'd10, 1'b0);
        fwd_case("forward x0", 1'b1, 5'd0, 1'b1, 5'd0, 1'b0);
        fwd_case("forward wb off", 1'b1, 5'd9, 1'b0, 5'd9, 1'b0);
        fwd_case("forward rs off", 1'b0, 5'd9, 1'b1, 5'd9, 1'b0);
        v = rnd64();
        alu_inst(v);
        compare_value("alu pass-through", v, res);
        confirm(res_wait == 0, "ALU instruction did not complete in its issue cycle");
    endtask

    task automatic model_csr_step(input csr_op_e op, input csr_addr_e adr,
                                  input logic [63:0] src, input logic [63:0] imm_v,
                                  inout logic [63:0] model);
        logic [63:0] opnd;
        run_csr(op, adr, src, imm_v);
        compare_value($sformatf("csr %s %s old", op.name(), adr.name()), model, res);
        opnd = (op inside {CSR_RWI, CSR_RSI, CSR_RCI}) ? {59'd0, imm_v[4:0]} : src;
        case (op)
            CSR_RW, CSR_RWI: model = opnd;
            CSR_RS, CSR_RSI: model = model | opnd;
            default:         model = model & ~opnd;
        endcase
    endtask

    task automatic csr_instructions();
        logic [63:0] model;
        logic [63:0] v;
        csr_addr_e   adr;
        for (int t = 0; t < 2; t++) begin
            adr   = (t == 0) ? CSR_MSCRATCH : CSR_MTVEC;
            model = '0;
            model_csr_step(CSR_RW, adr, rnd64(), '0, model);
            model_csr_step(CSR_RS, adr, 64'hf0f0_0000_f0f0_0000, '0, model);
            model_csr_step(CSR_RC, adr, 64'h00ff_00ff_00ff_00ff, '0, model);
            model_csr_step(CSR_RWI, adr, '0, 64'hffff_ffff_ffff_ffe5, model);  // Only imm[4:0] counts.
            model_csr_step(CSR_RSI, adr, '0, 64'h1a, model);
            model_csr_step(CSR_RCI, adr, '0, 64'h03, model);
            model_csr_step(CSR_RS, adr, '0, '0, model);
        end
        v          = rnd64();
        wb_rd_en   = 1'b1;
        wb_rd_idx  = 5'd3;
        wb_rd_data = v;
        run_csr(CSR_RW, CSR_MSCRATCH, rnd64(), '0);
        wb_rd_en   = 1'b0;
        run_csr(CSR_RS, CSR_MSCRATCH, '0, '0);
        compare_value("csr forwarded rs1", v, res);
    endtask

    task automatic trap_entry_exit();
        logic [31:0] vec;
        logic [31:0] epc;
        vec = 32'h8000_0100;
        epc = 32'h0000_4a5c;
        run_csr(CSR_RW, CSR_MTVEC, {32'd0, vec}, '0);
        pc = epc;
        system_inst(1'b1, 1'b0, 1'b0);
        confirm(res_trap, "ecall did not raise trap_o");
        compare_value("ecall nxt_pc", {32'd0, vec}, {32'd0, res_pc});
        pc = 32'h0000_0000;
        run_csr(CSR_RS, CSR_MEPC, '0, '0);
        compare_value("ecall mepc", {32'd0, epc}, res);
        run_csr(CSR_RS, CSR_MCAUSE, '0, '0);
        compare_value("ecall mcause", 64'd11, res);
        system_inst(1'b0, 1'b0, 1'b1);
        compare_value("mret nxt_pc", {32'd0, epc}, {32'd0, res_pc});
        pc = epc + 32'd4;
        system_inst(1'b0, 1'b1, 1'b0);
        confirm(res_trap, "ebreak did not raise trap_o");
        run_csr(CSR_RS, CSR_MCAUSE, '0, '0);
        compare_value("ebreak mcause", 64'd3, res);
    endtask

    task automatic clint_timer();
        logic [63:0] t0;
        logic [63:0] t1;
        int          seen;
        int          polls;
        seen = ext_cycles;
        write_mem(ST_D, MTIMECMP_ADR,
                  '{rs_en: 1'b1, rs_idx: 5'd7, rs_data: 64'h7000_0000_0000_0000});
        read_mem(LD_D, MTIMECMP_ADR);
        compare_value("clint mtimecmp", 64'h7000_0000_0000_0000, res);
        read_mem(LD_D, MTIME_ADR);
        t0 = res;
        read_mem(LD_D, MTIME_ADR);
        t1 = res;
        confirm(t1 > t0, "mtime did not increase between two reads");
        confirm(ext_cycles == seen, "CLINT access reached the external bus");
        run_csr(CSR_RW, CSR_MTVEC, 64'h8000_0200, '0);
        write_mem(ST_D, MTIMECMP_ADR, '{rs_en: 1'b1, rs_idx: 5'd7, rs_data: t1 + 64'd40});
        run_csr(CSR_RS, CSR_MIE, 64'h80, '0);      // MTIE.
        run_csr(CSR_RS, CSR_MSTATUS, 64'h08, '0);  // MIE.
        polls = 0;
        res   = '0;
        while (!res[7] && polls < POLL_MAX) begin
            run_csr(CSR_RS, CSR_MIP, '0, '0);
            confirm(!res_trap, "trap taken while intp_en_i was low");
            polls++;
        end
        confirm(res[7], "timer interrupt never became pending");
        pc = 32'h0000_6000;
        alu_inst(64'h1234);
        confirm(!res_trap, "trap taken while intp_en_i was low");
        intp_en = 1'b1;
        seen    = ext_cycles;
        read_mem(LD_D, 32'h0000_0300);  // The taken interrupt replaces this load.
        confirm(res_trap, "pending timer interrupt was not taken");
        confirm(res_wait == 0, "load under a taken interrupt waited for the bus");
        compare_value("irq nxt_pc", 64'h8000_0200, {32'd0, res_pc});
        run_csr(CSR_RS, CSR_MCAUSE, '0, '0);
        compare_value("irq mcause", {1'b1, 63'd7}, res);
        run_csr(CSR_RS, CSR_MEPC, '0, '0);
        compare_value("irq mepc", 64'h6000, res);
        confirm(ext_cycles == seen, "load under a taken interrupt started a bus cycle");
        intp_en = 1'b0;
    endtask

    initial begin
        init_all();
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        access_widths();
        forwarding_and_alu();
        csr_instructions();
        trap_entry_exit();
        clint_timer();
        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* filelist.f */
hw/mem_pkg.sv
hw/mem_forward.sv
hw/mem_lsu.sv
hw/mem_addr_decode.sv
hw/mem_clint.sv
hw/mem_csr.sv
hw/mem_top.sv
tests/mem_top_properties.sv
tests/mem_top_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= mem_top_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
